// File: hw/load_unit_pkg.sv
// ------------------------------------------------
// shared definitions of the load unit
// widths, load buffer sizes, opcode and state enums
// and the access size function used towards the cache
// ------------------------------------------------
`default_nettype none

package load_unit_pkg;

    // data and address width of the core
    localparam int unsigned XLEN          = 64;
    // byte offset bits inside one 64-bit word
    localparam int unsigned ALIGN_BITS    = 3;
    // number of loads that can be outstanding towards the cache
    localparam int unsigned NR_LDBUF      = 4;
    // the buffer index doubles as the cache request id
    localparam int unsigned LDBUF_ID_BITS = 2;
    // scoreboard transaction id width
    localparam int unsigned TRANS_ID_BITS = 3;
    // log2 of the access size in bytes fits in two bits
    localparam int unsigned DSIZE_BITS    = 2;

    // load opcodes, the U variants zero extend
    typedef enum logic [2:0] {
        LD, LW, LWU, LH, LHU, LB, LBU
    } load_op_e;

    // states of the request side
    typedef enum logic [1:0] {
        IDLE, WAIT_GNT, FLUSH_KILL
    } issue_state_e;

    // access size for the cache, as log2 of the byte count
    function automatic logic [DSIZE_BITS-1:0] load_size(load_op_e op);
        case (op)
            LD:       return 2'd3;
            LW, LWU:  return 2'd2;
            LH, LHU:  return 2'd1;
            default:  return 2'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: hw/load_issue_fsm.sv
// ------------------------------------------------
// request side state machine of the load unit
// raises the cache request, waits for the grant,
// pops the core queue and issues the flush kill
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module load_issue_fsm import load_unit_pkg::*; (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    input  logic valid_i,
    input  logic ldbuf_full_i,
    input  logic dgnt_i,
    output logic dreq_o,
    output logic kill_o,
    output logic pop_o,
    output logic ldbuf_we_o
);

    issue_state_e state_q, state_d;

    // ------------------------------------------------
    // next state and outputs
    // ------------------------------------------------
    always_comb begin
        state_d = state_q;
        dreq_o  = 1'b0;
        kill_o  = 1'b0;
        pop_o   = 1'b0;

        case (state_q)
            IDLE: begin
                // a new load only goes out when a buffer slot is free
                if (valid_i && !ldbuf_full_i) begin
                    dreq_o = 1'b1;
                    if (dgnt_i) begin
                        pop_o = 1'b1;
                    end else begin
                        state_d = WAIT_GNT;
                    end
                end
            end
            WAIT_GNT: begin
                // the request stays up with the same fields until granted
                dreq_o = 1'b1;
                if (dgnt_i) begin
                    pop_o   = 1'b1;
                    state_d = IDLE;
                end
            end
            FLUSH_KILL: begin
                // one cycle of kill tells the cache to drop its pending work
                kill_o  = 1'b1;
                state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase

        // flush wins over everything and drops a pending request without a pop
        if (flush_i) begin
            dreq_o  = 1'b0;
            pop_o   = 1'b0;
            state_d = FLUSH_KILL;
        end
    end

    // a granted request is recorded in the buffer of outstanding loads
    assign ldbuf_we_o = dreq_o & dgnt_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------------------------
    // assertions
    // ------------------------------------------------
    // the buffer never gets a request it cannot hold
    req_not_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dreq_o |-> !ldbuf_full_i);

    // an ungranted request is held until grant unless a flush drops it
    req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (dreq_o && !dgnt_i) |=> (dreq_o || flush_i));

endmodule

`default_nettype wire

// File: hw/load_buffer.sv
// ------------------------------------------------
// buffer of outstanding loads
// allocates the lowest free slot on grant, tracks
// flushed loads and looks up entries by response id
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module load_buffer import load_unit_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    // write side, one granted load per cycle
    input  logic                     we_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,
    input  load_op_e                 op_i,
    input  logic [ALIGN_BITS-1:0]    offset_i,
    // response side from the cache
    input  logic                     rvalid_i,
    input  logic [LDBUF_ID_BITS-1:0] rid_i,
    output logic [LDBUF_ID_BITS-1:0] free_id_o,
    output logic                     full_o,
    output logic                     hit_o,
    output logic [TRANS_ID_BITS-1:0] trans_id_o,
    output load_op_e                 op_o,
    output logic [ALIGN_BITS-1:0]    offset_o
);

    // control bits per entry
    logic [NR_LDBUF-1:0]      valid_q, valid_d;
    logic [NR_LDBUF-1:0]      flushed_q, flushed_d;
    // payload per entry
    logic [TRANS_ID_BITS-1:0] trans_id_q [NR_LDBUF];
    load_op_e                 op_q       [NR_LDBUF];
    logic [ALIGN_BITS-1:0]    offset_q   [NR_LDBUF];

    // ------------------------------------------------
    // slot allocation
    // ------------------------------------------------
    // scan from the top so the lowest free entry wins
    always_comb begin
        free_id_o = '0;
        for (int i = NR_LDBUF - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_id_o = LDBUF_ID_BITS'(i);
            end
        end
    end

    assign full_o = &valid_q;

    // ------------------------------------------------
    // valid and flushed flags
    // ------------------------------------------------
    always_comb begin
        valid_d   = valid_q;
        flushed_d = flushed_q;
        // every load in flight becomes flushed, its answer is swallowed later
        if (flush_i) begin
            flushed_d = '1;
        end
        // a response frees its slot whether flushed or not
        if (rvalid_i) begin
            valid_d[rid_i] = 1'b0;
        end
        // a new load starts out unflushed
        if (we_i) begin
            valid_d[free_id_o]   = 1'b1;
            flushed_d[free_id_o] = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q   <= '0;
            flushed_q <= '0;
        end else begin
            valid_q   <= valid_d;
            flushed_q <= flushed_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            trans_id_q[free_id_o] <= trans_id_i;
            op_q[free_id_o]       <= op_i;
            offset_q[free_id_o]   <= offset_i;
        end
    end

    // ------------------------------------------------
    // lookup by response id
    // ------------------------------------------------
    assign hit_o      = valid_q[rid_i] & ~flushed_q[rid_i];
    assign trans_id_o = trans_id_q[rid_i];
    assign op_o       = op_q[rid_i];
    assign offset_o   = offset_q[rid_i];

    // the issue side only writes when a slot is free
    no_overwrite: assert property (@(posedge clk_i) disable iff (!rst_ni)
        we_i |-> !valid_q[free_id_o]);

    // the cache only answers ids it was granted
    rsp_known_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_i |-> valid_q[rid_i]);

endmodule

`default_nettype wire

// File: hw/load_result_align.sv
// ------------------------------------------------
// realigns cache read data and sign or zero
// extends it according to the load opcode
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module load_result_align import load_unit_pkg::*; (
    input  load_op_e              op_i,
    input  logic [ALIGN_BITS-1:0] offset_i,
    input  logic [XLEN-1:0]       rdata_i,
    output logic [XLEN-1:0]       result_o
);

    logic [XLEN-1:0]       shifted;
    logic [XLEN/8-1:0]     sign_bits;
    logic [ALIGN_BITS-1:0] sign_offset;
    logic                  is_signed;
    logic                  sign_bit;

    // bring the addressed byte down to bit zero
    assign shifted = rdata_i >> {offset_i, 3'b000};

    // top bit of every byte, one of them is the sign of the field
    for (genvar i = 0; i < XLEN / 8; i++) begin : gen_sign_bits
        assign sign_bits[i] = rdata_i[8*i+7];
    end

    // the sign sits in the highest byte of the accessed field
    // this picks it from unshifted data so it runs beside the shifter
    always_comb begin
        case (op_i)
            LW:      sign_offset = offset_i + ALIGN_BITS'(3);
            LH:      sign_offset = offset_i + ALIGN_BITS'(1);
            default: sign_offset = offset_i;
        endcase
    end

    assign is_signed = op_i inside {LW, LH, LB};
    // unsigned loads pull the extension to zero
    assign sign_bit  = is_signed & sign_bits[sign_offset];

    // ------------------------------------------------
    // result mux
    // ------------------------------------------------
    always_comb begin
        case (op_i)
            LW, LWU: result_o = {{XLEN-32{sign_bit}}, shifted[31:0]};
            LH, LHU: result_o = {{XLEN-16{sign_bit}}, shifted[15:0]};
            LB, LBU: result_o = {{XLEN-8{sign_bit}}, shifted[7:0]};
            // a doubleword load uses the whole word
            default: result_o = shifted;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/load_unit.sv
// ------------------------------------------------
// load unit top level
// issue state machine, buffer of outstanding loads
// and result aligner between core and data cache
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module load_unit import load_unit_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    // load request from the issue queue
    input  logic                     valid_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,
    input  logic [XLEN-1:0]          vaddr_i,
    input  load_op_e                 op_i,
    output logic                     pop_o,
    // cache request
    output logic                     dreq_o,
    output logic [XLEN-1:0]          daddr_o,
    output logic [DSIZE_BITS-1:0]    dsize_o,
    output logic [LDBUF_ID_BITS-1:0] did_o,
    output logic                     kill_o,
    input  logic                     dgnt_i,
    // cache response
    input  logic                     drvalid_i,
    input  logic [LDBUF_ID_BITS-1:0] drid_i,
    input  logic [XLEN-1:0]          drdata_i,
    // result to the core
    output logic                     valid_o,
    output logic [TRANS_ID_BITS-1:0] trans_id_o,
    output logic [XLEN-1:0]          result_o
);

    logic                  ldbuf_full;
    logic                  ldbuf_we;
    logic                  ldbuf_hit;
    load_op_e              rsp_op;
    logic [ALIGN_BITS-1:0] rsp_offset;

    // the address is physical and goes to the cache unchanged
    assign daddr_o = vaddr_i;
    assign dsize_o = load_size(op_i);

    load_issue_fsm i_issue_fsm (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .valid_i      (valid_i),
        .ldbuf_full_i (ldbuf_full),
        .dgnt_i       (dgnt_i),
        .dreq_o       (dreq_o),
        .kill_o       (kill_o),
        .pop_o        (pop_o),
        .ldbuf_we_o   (ldbuf_we)
    );

    // the free slot index is the id the cache sends back
    load_buffer i_load_buffer (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .flush_i    (flush_i),
        .we_i       (ldbuf_we),
        .trans_id_i (trans_id_i),
        .op_i       (op_i),
        .offset_i   (vaddr_i[ALIGN_BITS-1:0]),
        .rvalid_i   (drvalid_i),
        .rid_i      (drid_i),
        .free_id_o  (did_o),
        .full_o     (ldbuf_full),
        .hit_o      (ldbuf_hit),
        .trans_id_o (trans_id_o),
        .op_o       (rsp_op),
        .offset_o   (rsp_offset)
    );

    load_result_align i_result_align (
        .op_i     (rsp_op),
        .offset_i (rsp_offset),
        .rdata_i  (drdata_i),
        .result_o (result_o)
    );

    // answers to flushed loads are swallowed here
    assign valid_o = drvalid_i & ldbuf_hit;

endmodule

`default_nettype wire

// File: verification/tb_load_unit.sv
// ------------------------------------------------
// testbench of the load unit
// clock, reset, cache model with grant delay and
// reordered responses, reference model, checks
// and the directed tests
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_load_unit import load_unit_pkg::*; ();

    // all tests together take a few hundred cycles
    localparam int          TIMEOUT_CYCLES = 2000;
    localparam int          POP_LIMIT      = 50;
    // aligned to 128 bytes so address bits 6:3 index the memory model
    localparam logic [63:0] BASE_ADDR      = 64'h0000_0000_8000_1000;

    logic                     clk_i;
    logic                     rst_ni;
    logic                     flush_i;
    logic                     valid_i;
    logic [TRANS_ID_BITS-1:0] trans_id_i;
    logic [XLEN-1:0]          vaddr_i;
    load_op_e                 op_i;
    logic                     pop_o;
    logic                     dreq_o;
    logic [XLEN-1:0]          daddr_o;
    logic [DSIZE_BITS-1:0]    dsize_o;
    logic [LDBUF_ID_BITS-1:0] did_o;
    logic                     kill_o;
    logic                     dgnt_i = 1'b0;
    logic                     drvalid_i;
    logic [LDBUF_ID_BITS-1:0] drid_i;
    logic [XLEN-1:0]          drdata_i;
    logic                     valid_o;
    logic [TRANS_ID_BITS-1:0] trans_id_o;
    logic [XLEN-1:0]          result_o;

    // granted loads wait in the cache model until a test answers them
    logic [XLEN-1:0]          mem [16];
    logic [LDBUF_ID_BITS-1:0] pend_id [$];
    logic [XLEN-1:0]          pend_addr [$];
    int                       gnt_delay = 0;
    int                       gnt_wait  = 0;
    logic                     dgnt_next = 1'b1;
    // the reference model keeps one entry per popped load that still owes a result
    logic [TRANS_ID_BITS-1:0] ref_tid [$];
    logic [XLEN-1:0]          ref_res [$];

    int    seed;
    int    tid_ctr      = 0;
    int    cycle_cnt    = 0;
    int    kill_cnt     = 0;
    int    results_seen = 0;
    int    chk_cnt      = 0;
    int    err_cnt      = 0;
    string test_name    = "reset";

    load_unit DUT (.*);

    always #2 clk_i = ~clk_i;

    // ------------------------------------------------
    // helpers
    // ------------------------------------------------
    task automatic step();
        @(posedge clk_i);
        #0.5;
    endtask

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        chk_cnt++;
        if (expected !== actual) begin
            $display("ERROR: %s, %s: expected %h, actual %h", test_name, what, expected, actual);
            err_cnt++;
        end
    endtask

    function automatic int access_bytes(input load_op_e op);
        case (op)
            LD:       return 8;
            LW, LWU:  return 4;
            LH, LHU:  return 2;
            default:  return 1;
        endcase
    endfunction

    // shift the addressed bytes down, then extend from the top bit of the field
    function automatic logic [63:0] expect_result(input load_op_e op, input logic [63:0] data,
                                                  input logic [2:0] off);
        logic [63:0] s;
        s = data >> (8 * off);
        case (op)
            LW:      return {{32{s[31]}}, s[31:0]};
            LWU:     return {32'b0, s[31:0]};
            LH:      return {{48{s[15]}}, s[15:0]};
            LHU:     return {48'b0, s[15:0]};
            LB:      return {{56{s[7]}}, s[7:0]};
            LBU:     return {56'b0, s[7:0]};
            default: return s;
        endcase
    endfunction

    // a transaction id that no outstanding load is using
    function automatic int next_tid();
        int tid;
        bit busy;
        tid = tid_ctr;
        do begin
            tid  = (tid + 1) % 8;
            busy = 1'b0;
            foreach (ref_tid[i]) begin
                if (int'(ref_tid[i]) == tid)
                    busy = 1'b1;
            end
        end while (busy);
        tid_ctr = tid;
        return tid;
    endfunction

    // the lowest slot that no granted and unanswered load holds
    function automatic int lowest_free_id();
        int id;
        bit busy;
        id = -1;
        for (int i = 0; i < NR_LDBUF; i++) begin
            busy = 1'b0;
            foreach (pend_id[j]) begin
                if (int'(pend_id[j]) == i)
                    busy = 1'b1;
            end
            if (!busy && id < 0)
                id = i;
        end
        return id;
    endfunction

    // results are matched by transaction id since the cache reorders them
    task automatic match_result();
        int found;
        found = -1;
        foreach (ref_tid[i]) begin
            if (found < 0 && ref_tid[i] == trans_id_o)
                found = i;
        end
        if (found < 0) begin
            $display("%s: result for trans id %0d was not expected", test_name, trans_id_o);
            err_cnt++;
        end else begin
            check("result", ref_res[found], result_o);
            ref_tid.delete(found);
            ref_res.delete(found);
        end
        results_seen++;
    endtask

    task automatic sample_cycle();
        if (kill_o)
            kill_cnt++;
        if (dreq_o && dgnt_i) begin
            check("request id", 64'(lowest_free_id()), 64'(did_o));
            pend_id.push_back(did_o);
            pend_addr.push_back(daddr_o);
            check("access size", 64'(access_bytes(op_i)), 64'(1) << dsize_o);
            gnt_wait = 0;
        end else if (dreq_o) begin
            gnt_wait++;
        end else begin
            gnt_wait = 0;
        end
        // the grant for the next cycle follows the current delay
        dgnt_next = (gnt_wait >= gnt_delay);
        if (pop_o && valid_i) begin
            ref_tid.push_back(trans_id_i);
            ref_res.push_back(expect_result(op_i, mem[vaddr_i[6:3]], vaddr_i[2:0]));
        end
        if (valid_o)
            match_result();
        // flushed loads still get answered but must not return a result
        if (flush_i) begin
            ref_tid.delete();
            ref_res.delete();
        end
    endtask

    // grant is driven with the inputs and outputs are sampled late in the cycle
    always @(posedge clk_i) begin
        #0.5;
        dgnt_i = dgnt_next;
        #1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_cnt);
            $display("Test failures found");
            $finish;
        end else if (rst_ni) begin
            cycle_cnt++;
            sample_cycle();
        end
    end

    task automatic issue_load(input int tid, input logic [63:0] addr, input load_op_e op);
        int waited;
        waited     = 0;
        valid_i    = 1'b1;
        trans_id_i = 3'(tid);
        vaddr_i    = addr;
        op_i       = op;
        #1;
        while (!pop_o && waited < POP_LIMIT) begin
            step();
            #1;
            waited++;
        end
        if (!pop_o) begin
            $display("%s: load with trans id %0d was never popped", test_name, tid);
            err_cnt++;
        end
        step();
        valid_i = 1'b0;
    endtask

    // answer the granted load at position idx of the pending queue
    task automatic respond(input int idx);
        if (idx < 0 || idx >= pend_id.size()) begin
            $display("%s: no granted load left to answer", test_name);
            err_cnt++;
        end else begin
            drvalid_i = 1'b1;
            drid_i    = pend_id[idx];
            drdata_i  = mem[pend_addr[idx][6:3]];
            pend_id.delete(idx);
            pend_addr.delete(idx);
            step();
            drvalid_i = 1'b0;
        end
    endtask

    task automatic expect_drained();
        repeat (2) step();
        if (ref_tid.size() != 0) begin
            $display("%s: %0d expected results never came back", test_name, ref_tid.size());
            err_cnt++;
        end
        if (pend_id.size() != 0) begin
            $display("%s: granted loads were left unanswered", test_name);
            err_cnt++;
        end
    endtask

    // ------------------------------------------------
    // directed tests
    // ------------------------------------------------
    task automatic test_extension();
        load_op_e op;
        test_name = "extension";
        gnt_delay = 0;
        for (int k = 0; k < 7; k++) begin
            op = load_op_e'(3'(k));
            for (int off = 0; off < 8; off += access_bytes(op)) begin
                issue_load(next_tid(), BASE_ADDR + 64'((k + off) % 16 * 8 + off), op);
                respond(0);
            end
        end
        expect_drained();
    endtask

    task automatic test_grant_delay();
        int waited;
        int results_before;
        logic [63:0] addr;
        test_name = "grant delay";
        gnt_delay = 5;
        step();
        // halfword at word 5, offset 6
        addr           = BASE_ADDR + 64'h2e;
        results_before = results_seen;
        waited         = 0;
        valid_i        = 1'b1;
        trans_id_i     = 3'(next_tid());
        vaddr_i        = addr;
        op_i           = LH;
        #1;
        while (!pop_o && waited < 20) begin
            check("request held", 64'(1), 64'(dreq_o));
            check("address held", addr, daddr_o);
            waited++;
            step();
            #1;
        end
        check("cycles without grant", 64'(5), 64'(waited));
        step();
        valid_i = 1'b0;
        respond(0);
        expect_drained();
        check("results", 64'(1), 64'(results_seen - results_before));
    endtask

    task automatic test_out_of_order();
        int tid;
        test_name = "out of order";
        gnt_delay = 0;
        for (int n = 0; n < 4; n++)
            issue_load(next_tid(), BASE_ADDR + 64'(n * 16 + 2 * n), LH);
        check("loads in flight", 64'(4), 64'(pend_id.size()));
        // a fifth load has to wait for a free slot
        tid        = next_tid();
        valid_i    = 1'b1;
        trans_id_i = 3'(tid);
        vaddr_i    = BASE_ADDR + 64'h74;
        op_i       = LWU;
        repeat (3) begin
            #1;
            check("pop while full", 64'(0), 64'(pop_o));
            check("request while full", 64'(0), 64'(dreq_o));
            step();
        end
        respond(pend_id.size() - 1);
        issue_load(tid, BASE_ADDR + 64'h74, LWU);
        while (pend_id.size() > 0)
            respond(pend_id.size() - 1);
        expect_drained();
    endtask

    task automatic test_flush();
        int kills_before;
        int results_before;
        test_name = "flush";
        gnt_delay = 0;
        for (int n = 0; n < 3; n++)
            issue_load(next_tid(), BASE_ADDR + 64'(n * 8 + 8), LD);
        // the next request sits in WAIT_GNT when the flush comes
        gnt_delay = 20;
        step();
        valid_i    = 1'b1;
        trans_id_i = 3'(next_tid());
        vaddr_i    = BASE_ADDR + 64'h40;
        op_i       = LW;
        repeat (2) step();
        kills_before   = kill_cnt;
        results_before = results_seen;
        flush_i        = 1'b1;
        #1;
        check("pop at flush", 64'(0), 64'(pop_o));
        step();
        flush_i = 1'b0;
        valid_i = 1'b0;
        repeat (3) step();
        check("kill cycles", 64'(1), 64'(kill_cnt - kills_before));
        check("granted before flush", 64'(3), 64'(pend_id.size()));
        gnt_delay = 0;
        while (pend_id.size() > 0)
            respond(0);
        step();
        check("flushed results", 64'(0), 64'(results_seen - results_before));
        issue_load(next_tid(), BASE_ADDR + 64'h4b, LBU);
        respond(0);
        expect_drained();
        check("results after flush", 64'(1), 64'(results_seen - results_before));
    endtask

    task automatic test_random();
        int size;
        int off;
        int word;
        load_op_e op;
        test_name = "random";
        for (int n = 0; n < 40; n++) begin
            op        = load_op_e'(3'($unsigned($random(seed)) % 7));
            size      = access_bytes(op);
            off       = int'($unsigned($random(seed)) % 8) / size * size;
            word      = int'($unsigned($random(seed)) % 16);
            gnt_delay = int'($unsigned($random(seed)) % 4);
            // answer some loads early, and always when every slot is busy
            while (pend_id.size() == NR_LDBUF || (pend_id.size() > 0 && $random(seed) % 3 == 0))
                respond(int'($unsigned($random(seed)) % pend_id.size()));
            issue_load(next_tid(), BASE_ADDR + 64'(word * 8 + off), op);
        end
        while (pend_id.size() > 0)
            respond(int'($unsigned($random(seed)) % pend_id.size()));
        expect_drained();
    endtask

    initial begin
        seed       = 32'h9f3b;
        clk_i      = 1'b0;
        rst_ni     = 1'b0;
        flush_i    = 1'b0;
        valid_i    = 1'b0;
        trans_id_i = '0;
        vaddr_i    = '0;
        op_i       = LD;
        drvalid_i  = 1'b0;
        drid_i     = '0;
        drdata_i   = '0;
        for (int i = 0; i < 16; i++)
            mem[i] = {$random(seed), $random(seed)};
        repeat (4) @(posedge clk_i);
        #0.5;
        rst_ni = 1'b1;
        step();
        test_extension();
        test_grant_delay();
        test_out_of_order();
        test_flush();
        test_random();
        repeat (4) step();
        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: load_unit.f
hw/load_unit_pkg.sv
hw/load_issue_fsm.sv
hw/load_buffer.sv
hw/load_result_align.sv
hw/load_unit.sv
verification/tb_load_unit.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_load_unit
RTL_TOP   ?= load_unit
FLIST     ?= load_unit.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  := All tests passed!

SRCS     := $(filter-out +%,$(shell cat $(FLIST)))
RTL_SRCS := $(filter hw/%,$(SRCS))
BIN      := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
